/* all.f */
hdl/csr_pkg.sv
hdl/csr_timer.sv
hdl/csr_trap_ctrl.sv
hdl/csr_regfile.sv
hdl/csr_unit.sv
test/csr_unit_tb.sv

/* Bender.yml */
package:
  name: csr_unit

sources:
  - files:
      - hdl/csr_pkg.sv
      - hdl/csr_timer.sv
      - hdl/csr_trap_ctrl.sv
      - hdl/csr_regfile.sv
      - hdl/csr_unit.sv
  - target: test
    files:
      - test/csr_unit_tb.sv

/* test/csr_unit_tb.sv */
`timescale 1ns/1ns

module csr_unit_tb;

    import csr_pkg::*;

    // Limit covers the planned commands with flush bubbles and reset
    localparam int N_CMDS = 55;
    localparam int LIMIT  = 4 * N_CMDS + 200;

    logic      clk;
    logic      arst_n;
    logic      cmd_valid;
    csr_op_e   cmd_op;
    csr_addr_t cmd_addr;
    xlen_t     cmd_wdata;
    xlen_t     cmd_pc;
    logic      cmd_ready;
    logic      rsp_valid;
    xlen_t     rsp_rdata;
    logic      trap_valid;
    xlen_t     trap_pc;

    // Reference model state
    priv_e     priv_m;
    priv_e     mpp_m;
    logic      mie_m;
    logic      mpie_m;
    logic      mtie_m;
    logic      pend_m;
    xlen_t     mtvec_m;
    xlen_t     mscratch_m;
    xlen_t     mepc_m;
    xlen_t     mcause_m;
    xlen_t     cmp_lo_m;
    xlen_t     cmp_hi_m;

    // Expected result of the command about to be accepted
    logic      exp_rsp;
    logic      exp_ctr;
    xlen_t     exp_data;
    // Expectation delayed to the result cycle
    logic      acc_d;
    logic      rsp_d;
    logic      ctr_d;
    xlen_t     data_d;
    xlen_t     ctr_last;
    logic [31:0] rng_state;
    int        cycles;

    csr_unit #(
        .TICK_DIV (4)
    ) uut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // Architectural old value without the counters
    function automatic xlen_t model_read(input csr_addr_t addr);
        xlen_t v;
        v = '0;
        case (addr)
            ADDR_MSTATUS: begin
                v[3]     = mie_m;
                v[7]     = mpie_m;
                v[12:11] = mpp_m;
            end
            ADDR_MISA:      v = MISA_VALUE;
            ADDR_MIE:       v[7] = mtie_m;
            ADDR_MTVEC:     v = mtvec_m;
            ADDR_MSCRATCH:  v = mscratch_m;
            ADDR_MEPC:      v = mepc_m;
            ADDR_MCAUSE:    v = mcause_m;
            ADDR_MIP:       v[7] = pend_m;
            ADDR_MTIMECMP:  v = cmp_lo_m;
            ADDR_MTIMECMPH: v = cmp_hi_m;
            default:        v = '0;
        endcase
        return v;
    endfunction

    function automatic void model_write(input csr_addr_t addr, input xlen_t nv);
        case (addr)
            ADDR_MSTATUS: begin
                mie_m  = nv[3];
                mpie_m = nv[7];
                // Only U and M exist for MPP
                mpp_m  = (nv[12:11] == 2'b11) ? PRIV_M : PRIV_U;
            end
            ADDR_MIE:       mtie_m = nv[7];
            ADDR_MTVEC:     mtvec_m = {nv[31:2], 1'b0, nv[0]};
            ADDR_MSCRATCH:  mscratch_m = nv;
            ADDR_MEPC:      mepc_m = {nv[31:2], 2'b00};
            ADDR_MCAUSE:    mcause_m = nv;
            ADDR_MTIMECMP:  cmp_lo_m = nv;
            ADDR_MTIMECMPH: cmp_hi_m = nv;
            default: begin
            end
        endcase
        // Timer pending once mtimecmp is zero
        pend_m = ({cmp_hi_m, cmp_lo_m} == 64'd0);
    endfunction

    // Drive at a falling edge, hold until ready, predict, return at next falling edge
    task automatic send(input csr_op_e op, input csr_addr_t addr, input xlen_t wd);
        xlen_t pc;
        xlen_t old;
        xlen_t nv;
        logic  irq;
        pc        = next_rand();
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_wdata = wd;
        cmd_pc    = pc;
        while (!cmd_ready) @(negedge clk);
        irq     = (mie_m || (priv_m == PRIV_U)) && mtie_m && pend_m;
        exp_ctr = 1'b0;
        if (irq || (op == CSR_ECALL)) begin
            exp_rsp  = 1'b0;
            // Vectored interrupt lands four bytes per cause code above base
            exp_data = {mtvec_m[31:2], 2'b00} + ((irq && mtvec_m[0]) ? 32'd28 : 32'd0);
            mepc_m   = {pc[31:2], 2'b00};
            mcause_m = irq ? 32'h8000_0007 : ((priv_m == PRIV_U) ? 32'd8 : 32'd11);
            mpie_m   = mie_m;
            mie_m    = 1'b0;
            mpp_m    = priv_m;
            priv_m   = PRIV_M;
        end else if (op == CSR_MRET) begin
            exp_rsp  = 1'b0;
            exp_data = mepc_m;
            priv_m   = mpp_m;
            mie_m    = mpie_m;
            mpie_m   = 1'b1;
            mpp_m    = PRIV_U;
        end else begin
            exp_rsp  = 1'b1;
            old      = (priv_m >= addr[9:8]) ? model_read(addr) : '0;
            exp_data = old;
            exp_ctr  = addr inside {ADDR_CYCLE, ADDR_CYCLEH, ADDR_TIME, ADDR_TIMEH};
            if (op == CSR_RS) begin
                nv = old | wd;
            end else if (op == CSR_RC) begin
                nv = old & ~wd;
            end else begin
                nv = wd;
            end
            if ((priv_m >= addr[9:8]) && (addr[11:10] != 2'b11)) begin
                model_write(addr, nv);
            end
        end
        @(negedge clk);
    endtask

    // Line up the prediction with the result cycle
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_d    <= 1'b0;
            rsp_d    <= 1'b0;
            ctr_d    <= 1'b0;
            data_d   <= '0;
            ctr_last <= '0;
        end else begin
            acc_d <= cmd_valid && cmd_ready;
            if (cmd_valid && cmd_ready) begin
                rsp_d  <= exp_rsp;
                ctr_d  <= exp_ctr;
                data_d <= exp_data;
            end
            if (acc_d && rsp_d && ctr_d) begin
                ctr_last <= rsp_rdata;
            end
        end
    end

    a_kind: assert property (@(posedge clk) disable iff (!arst_n)
        acc_d |-> (rsp_valid == rsp_d) && (trap_valid == !rsp_d))
        else report_error("wrong result kind for accepted command");
    a_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !acc_d |-> !rsp_valid && !trap_valid)
        else report_error("result without accepted command");
    a_rdata: assert property (@(posedge clk) disable iff (!arst_n)
        acc_d && rsp_d && !ctr_d |-> rsp_rdata == data_d)
        else report_error($sformatf("rsp_rdata %h, expected %h",
                                    $sampled(rsp_rdata), $sampled(data_d)));
    // Time reads come before cycle reads so one chain never drops
    a_counter: assert property (@(posedge clk) disable iff (!arst_n)
        acc_d && rsp_d && ctr_d |-> (rsp_rdata >= ctr_last) && (rsp_rdata != 0))
        else report_error($sformatf("counter %h after %h",
                                    $sampled(rsp_rdata), $sampled(ctr_last)));
    a_trap_pc: assert property (@(posedge clk) disable iff (!arst_n)
        acc_d && !rsp_d |-> trap_pc == data_d)
        else report_error($sformatf("trap_pc %h, expected %h",
                                    $sampled(trap_pc), $sampled(data_d)));
    a_bubble: assert property (@(posedge clk) disable iff (!arst_n)
        trap_valid |-> !cmd_ready ##1 cmd_ready)
        else report_error("cmd_ready not low for exactly one cycle after redirect");

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

    initial begin
        cycles     = 0;
        rng_state  = 32'heef1_aba7;
        arst_n     = 1'b0;
        cmd_valid  = 1'b0;
        cmd_op     = CSR_NONE;
        cmd_addr   = '0;
        cmd_wdata  = '0;
        cmd_pc     = '0;
        priv_m     = PRIV_M;
        mpp_m      = PRIV_M;
        mie_m      = 1'b0;
        mpie_m     = 1'b0;
        mtie_m     = 1'b0;
        pend_m     = 1'b0;
        mtvec_m    = '0;
        mscratch_m = '0;
        mepc_m     = '0;
        mcause_m   = '0;
        cmp_lo_m   = '1;
        cmp_hi_m   = '1;
        exp_rsp    = 1'b0;
        exp_ctr    = 1'b0;
        exp_data   = '0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        // Read-modify-write back to back
        repeat (6) begin
            send(CSR_RW, ADDR_MSCRATCH, next_rand());
            send(CSR_RS, ADDR_MSCRATCH, next_rand());
            send(CSR_RC, ADDR_MSCRATCH, next_rand());
        end
        send(CSR_RW, ADDR_MCAUSE, next_rand());
        send(CSR_RS, ADDR_MCAUSE, '0);
        send(CSR_RW, ADDR_MTVEC, next_rand());
        send(CSR_RS, ADDR_MTVEC, '0);
        // Fixed MISA and the unknown address 0x7FF
        send(CSR_RW, ADDR_MISA, next_rand());
        send(CSR_RS, ADDR_MISA, '0);
        send(CSR_RS, 12'h7FF, '0);
        // ECALL from M
        send(CSR_ECALL, '0, '0);
        send(CSR_RS, ADDR_MCAUSE, '0);
        send(CSR_RS, ADDR_MEPC, '0);
        // MPP to U, return, then U accesses
        send(CSR_RC, ADDR_MSTATUS, 32'h0000_1800);
        send(CSR_MRET, '0, '0);
        send(CSR_RS, ADDR_MSCRATCH, '0);
        send(CSR_RW, ADDR_MSCRATCH, next_rand());
        send(CSR_ECALL, '0, '0);
        send(CSR_RS, ADDR_MSCRATCH, '0);
        send(CSR_RS, ADDR_MCAUSE, '0);
        send(CSR_RS, ADDR_MSTATUS, '0);
        // Counters from M and then from U
        repeat (3) send(CSR_RS, ADDR_TIME, '0);
        send(CSR_MRET, '0, '0);
        repeat (2) send(CSR_RS, ADDR_TIME, '0);
        repeat (3) send(CSR_RS, ADDR_CYCLE, '0);
        send(CSR_ECALL, '0, '0);
        // Vectored timer interrupt
        send(CSR_RW, ADDR_MTVEC, next_rand() | 32'd1);
        send(CSR_RS, ADDR_MIE, 32'h0000_0080);
        send(CSR_RS, ADDR_MSTATUS, 32'h0000_0008);
        send(CSR_RW, ADDR_MTIMECMP, '0);
        send(CSR_RW, ADDR_MTIMECMPH, '0);
        send(CSR_RS, ADDR_MSCRATCH, '0);
        send(CSR_RS, ADDR_MCAUSE, '0);
        send(CSR_RS, ADDR_MEPC, '0);
        send(CSR_RS, ADDR_MSTATUS, '0);
        cmd_valid = 1'b0;
        cmd_op    = CSR_NONE;
        // Let the last results pass the checks
        repeat (3) @(negedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* hdl/csr_unit.sv */
`timescale 1ns/1ns

module csr_unit #(
    parameter int TICK_DIV = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               cmd_valid,
    input  csr_pkg::csr_op_e   cmd_op,
    input  csr_pkg::csr_addr_t cmd_addr,
    input  csr_pkg::xlen_t     cmd_wdata,
    input  csr_pkg::xlen_t     cmd_pc,
    output logic               cmd_ready,
    output logic               rsp_valid,
    output csr_pkg::xlen_t     rsp_rdata,
    output logic               trap_valid,
    output csr_pkg::xlen_t     trap_pc
);

    import csr_pkg::*;

    // Controller to register file
    logic        exec_en;
    logic        trap_enter;
    xlen_t       trap_cause;
    logic        mret_en;
    priv_e       priv;

    // Register file to controller
    logic        irq_ready;
    xlen_t       tvec_base;
    logic        tvec_vectored;
    xlen_t       mepc;
    priv_e       saved_mpp;

    // Timer and its compare write port
    logic [63:0] cycle;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        timer_pending;
    logic        cmp_wr_lo;
    logic        cmp_wr_hi;
    xlen_t       cmp_wdata;

    // Port names match the nets above
    csr_trap_ctrl u_trap_ctrl (.*);

    csr_regfile u_regfile (.*);

    csr_timer #(
        .TICK_DIV (TICK_DIV)
    ) u_timer (.*);

endmodule

/* hdl/csr_regfile.sv */
`timescale 1ns/1ns

module csr_regfile (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               exec_en,
    input  logic               trap_enter,
    input  csr_pkg::xlen_t     trap_cause,
    input  logic               mret_en,
    input  csr_pkg::priv_e     priv,
    input  csr_pkg::csr_op_e   cmd_op,
    input  csr_pkg::csr_addr_t cmd_addr,
    input  csr_pkg::xlen_t     cmd_wdata,
    input  csr_pkg::xlen_t     cmd_pc,
    input  logic [63:0]        cycle,
    input  logic [63:0]        mtime,
    input  logic [63:0]        mtimecmp,
    input  logic               timer_pending,
    output csr_pkg::xlen_t     rsp_rdata,
    output logic               irq_ready,
    output csr_pkg::xlen_t     tvec_base,
    output logic               tvec_vectored,
    output csr_pkg::xlen_t     mepc,
    output csr_pkg::priv_e     saved_mpp,
    output logic               cmp_wr_lo,
    output logic               cmp_wr_hi,
    output csr_pkg::xlen_t     cmp_wdata
);

    import csr_pkg::*;

    // mstatus bits kept, MPP is saved_mpp
    logic        st_mie;
    logic        st_mpie;
    logic        mie_mtie;
    // mtvec base, mode bit is tvec_vectored
    logic [29:0] mtvec_base;
    xlen_t       mscratch;
    xlen_t       mcause;

    logic        access_ok;
    logic        write_ok;
    logic        is_rmw;
    logic        wr_en;
    xlen_t       mstatus_rd;
    xlen_t       mie_rd;
    xlen_t       mip_rd;
    xlen_t       csr_rd;
    xlen_t       old_val;
    xlen_t       new_val;
    priv_e       mpp_wr;

    // Address bits [9:8] give the lowest mode allowed
    assign access_ok = (priv >= cmd_addr[9:8]);
    // Bits [11:10] == 11 mark a read-only CSR
    assign write_ok  = access_ok && (cmd_addr[11:10] != 2'b11);
    assign is_rmw    = (cmd_op == CSR_RW) || (cmd_op == CSR_RS) || (cmd_op == CSR_RC);
    assign wr_en     = exec_en && is_rmw && write_ok;

    // Packed views of the sparse registers
    always_comb begin
        mstatus_rd                      = '0;
        mstatus_rd[MSTATUS_MIE]         = st_mie;
        mstatus_rd[MSTATUS_MPIE]        = st_mpie;
        mstatus_rd[MSTATUS_MPP_LO +: 2] = saved_mpp;
    end

    always_comb begin
        mie_rd         = '0;
        mie_rd[MIX_MT] = mie_mtie;
        // MTIP mirrors the timer, writes ignored
        mip_rd         = '0;
        mip_rd[MIX_MT] = timer_pending;
    end

    // Read mux
    always_comb begin
        case (cmd_addr)
            ADDR_CYCLE:     csr_rd = cycle[31:0];
            ADDR_CYCLEH:    csr_rd = cycle[63:32];
            ADDR_TIME:      csr_rd = mtime[31:0];
            ADDR_TIMEH:     csr_rd = mtime[63:32];
            ADDR_MSTATUS:   csr_rd = mstatus_rd;
            ADDR_MISA:      csr_rd = MISA_VALUE;
            ADDR_MIE:       csr_rd = mie_rd;
            ADDR_MTVEC:     csr_rd = {mtvec_base, 1'b0, tvec_vectored};
            ADDR_MSCRATCH:  csr_rd = mscratch;
            ADDR_MEPC:      csr_rd = mepc;
            ADDR_MCAUSE:    csr_rd = mcause;
            ADDR_MIP:       csr_rd = mip_rd;
            ADDR_MTIMECMP:  csr_rd = mtimecmp[31:0];
            ADDR_MTIMECMPH: csr_rd = mtimecmp[63:32];
            // Unknown address
            default:        csr_rd = '0;
        endcase
    end

    // Too little privilege reads as zero
    assign old_val = access_ok ? csr_rd : '0;

    // Write, set or clear against the old value
    always_comb begin
        case (cmd_op)
            CSR_RS:  new_val = old_val | cmd_wdata;
            CSR_RC:  new_val = old_val & ~cmd_wdata;
            default: new_val = cmd_wdata;
        endcase
    end

    // MPP is WARL, anything but M falls back to U
    assign mpp_wr = (new_val[MSTATUS_MPP_LO +: 2] == 2'b11) ? PRIV_M : PRIV_U;

    // mtimecmp lives in the timer
    assign cmp_wr_lo = wr_en && (cmd_addr == ADDR_MTIMECMP);
    assign cmp_wr_hi = wr_en && (cmd_addr == ADDR_MTIMECMPH);
    assign cmp_wdata = new_val;

    assign tvec_base = {mtvec_base, 2'b00};

    // MIE only gates while in M, U is always interruptible
    assign irq_ready = (st_mie || (priv == PRIV_U)) && mie_mtie && timer_pending;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st_mie        <= 1'b0;
            st_mpie       <= 1'b0;
            saved_mpp     <= PRIV_M;
            mie_mtie      <= 1'b0;
            mtvec_base    <= '0;
            tvec_vectored <= 1'b0;
            mscratch      <= '0;
            mepc          <= '0;
            mcause        <= '0;
        end else if (trap_enter) begin
            // Trap entry stacks the interrupt enable and mode
            mepc      <= {cmd_pc[31:2], 2'b00};
            mcause    <= trap_cause;
            st_mpie   <= st_mie;
            st_mie    <= 1'b0;
            saved_mpp <= priv;
        end else if (mret_en) begin
            st_mie    <= st_mpie;
            st_mpie   <= 1'b1;
            saved_mpp <= PRIV_U;
        end else if (wr_en) begin
            case (cmd_addr)
                ADDR_MSTATUS: begin
                    st_mie    <= new_val[MSTATUS_MIE];
                    st_mpie   <= new_val[MSTATUS_MPIE];
                    saved_mpp <= mpp_wr;
                end
                ADDR_MIE: begin
                    mie_mtie <= new_val[MIX_MT];
                end
                ADDR_MTVEC: begin
                    // Mode 0 direct, 1 vectored
                    mtvec_base    <= new_val[31:2];
                    tvec_vectored <= new_val[0];
                end
                ADDR_MSCRATCH: begin
                    mscratch <= new_val;
                end
                ADDR_MEPC: begin
                    mepc <= {new_val[31:2], 2'b00};
                end
                ADDR_MCAUSE: begin
                    mcause <= new_val;
                end
                default: begin
                    // Read-only or timer address
                end
            endcase
        end
    end

    // Old value goes back with the response
    always_ff @(posedge clk) begin
        if (exec_en) begin
            rsp_rdata <= old_val;
        end
    end

    // Controller never executes and traps the same command
    a_exec_xor_trap: assert property (@(posedge clk) disable iff (!arst_n)
        !(trap_enter && exec_en));

endmodule

/* hdl/csr_trap_ctrl.sv */
`timescale 1ns/1ns

module csr_trap_ctrl (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             cmd_valid,
    input  csr_pkg::csr_op_e cmd_op,
    input  csr_pkg::xlen_t   cmd_pc,
    input  logic             irq_ready,
    input  csr_pkg::xlen_t   tvec_base,
    input  logic             tvec_vectored,
    input  csr_pkg::xlen_t   mepc,
    input  csr_pkg::priv_e   saved_mpp,
    output logic             cmd_ready,
    output logic             exec_en,
    output logic             trap_enter,
    output csr_pkg::xlen_t   trap_cause,
    output logic             mret_en,
    output csr_pkg::priv_e   priv,
    output logic             rsp_valid,
    output logic             trap_valid,
    output csr_pkg::xlen_t   trap_pc
);

    import csr_pkg::*;

    ctrl_state_e state;
    logic        accept;
    logic        is_ecall;
    logic        is_mret;
    logic        redirect;
    xlen_t       vec_off;
    xlen_t       target;

    // Only take commands while running
    assign cmd_ready = (state == ST_RUN);
    assign accept    = cmd_valid && cmd_ready;
    assign is_ecall  = (cmd_op == CSR_ECALL);
    assign is_mret   = (cmd_op == CSR_MRET);

    // Pending timer interrupt replaces the command
    assign trap_enter = accept && (irq_ready || is_ecall);
    assign mret_en    = accept && !irq_ready && is_mret;
    assign exec_en    = accept && !irq_ready && !is_ecall && !is_mret;
    assign redirect   = trap_enter || mret_en;

    // Interrupt first, else ECALL code by current mode
    assign trap_cause = irq_ready        ? CAUSE_M_TIMER_IRQ :
                        (priv == PRIV_U) ? CAUSE_ECALL_U     : CAUSE_ECALL_M;

    // Vectored slot is four bytes per cause code
    assign vec_off = {trap_cause[29:0], 2'b00};

    // Redirect target
    always_comb begin
        if (mret_en) begin
            target = mepc;
        end else if (irq_ready && tvec_vectored) begin
            target = tvec_base + vec_off;
        end else begin
            // ECALL and direct mode share the base
            target = tvec_base;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ST_RUN;
            priv       <= PRIV_M;
            rsp_valid  <= 1'b0;
            trap_valid <= 1'b0;
        end else begin
            // Exactly one result per accepted command
            rsp_valid  <= exec_en;
            trap_valid <= redirect;
            case (state)
                ST_RUN: begin
                    if (redirect) begin
                        state <= ST_FLUSH;
                    end
                end
                default: begin
                    // Single bubble while the pipeline refetches
                    state <= ST_RUN;
                end
            endcase
            if (trap_enter) begin
                priv <= PRIV_M;
            end else if (mret_en) begin
                priv <= saved_mpp;
            end
        end
    end

    // New fetch address for the pipeline
    always_ff @(posedge clk) begin
        if (redirect) begin
            trap_pc <= target;
        end
    end

    // Redirect costs one stalled cycle, then commands flow again
    a_flush_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        trap_valid |-> !cmd_ready ##1 cmd_ready);

    a_one_result: assert property (@(posedge clk) disable iff (!arst_n)
        !(rsp_valid && trap_valid));

    // MRET restores MPP, which the register file keeps legal
    a_priv_legal: assert property (@(posedge clk) disable iff (!arst_n)
        priv inside {PRIV_U, PRIV_M});

    // Register file saves the aligned pc of the trapped command
    a_mepc_saved: assert property (@(posedge clk) disable iff (!arst_n)
        trap_enter |=> mepc == $past({cmd_pc[31:2], 2'b00}));

endmodule

/* hdl/csr_timer.sv */
`timescale 1ns/1ns

module csr_timer #(
    parameter int TICK_DIV = 4
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           cmp_wr_lo,
    input  logic           cmp_wr_hi,
    input  csr_pkg::xlen_t cmp_wdata,
    output logic [63:0]    cycle,
    output logic [63:0]    mtime,
    output logic [63:0]    mtimecmp,
    output logic           timer_pending
);

    // Prescaler holds 0 .. TICK_DIV-1, at least one bit wide
    localparam int            PW         = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [PW-1:0] PRESC_LAST = PW'(TICK_DIV - 1);

    logic [PW-1:0] presc;
    logic          tick;

    // One mtime tick per TICK_DIV clocks
    assign tick = (presc == PRESC_LAST);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            presc <= '0;
        end else if (tick) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // Free running, every clock
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtime <= '0;
        end else if (tick) begin
            mtime <= mtime + 64'd1;
        end
    end

    // All ones out of reset so nothing is pending
    // Halves written one at a time by CSR writes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtimecmp <= '1;
        end else begin
            if (cmp_wr_lo) begin
                mtimecmp[31:0] <= cmp_wdata;
            end
            if (cmp_wr_hi) begin
                mtimecmp[63:32] <= cmp_wdata;
            end
        end
    end

    // Seen in the cycle right after a compare write
    assign timer_pending = (mtime >= mtimecmp);

    // Monotonic time base
    a_mtime_monotonic: assert property (@(posedge clk) disable iff (!arst_n)
        mtime >= $past(mtime));

endmodule

/* hdl/csr_pkg.sv */
package csr_pkg;

    // Register word and CSR address
    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;

    // Command opcodes from the pipeline
    typedef enum logic [2:0] {
        CSR_NONE  = 3'd0,
        CSR_RW    = 3'd1,
        CSR_RS    = 3'd2,
        CSR_RC    = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_op_e;

    // Architectural encodings, only U and M exist here
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_e;

    // Controller FSM
    typedef enum logic {
        ST_RUN   = 1'b0,
        ST_FLUSH = 1'b1
    } ctrl_state_e;

    // Unprivileged counters, read only from any mode
    localparam csr_addr_t ADDR_CYCLE     = 12'hC00;
    localparam csr_addr_t ADDR_CYCLEH    = 12'hC80;
    localparam csr_addr_t ADDR_TIME      = 12'hC01;
    localparam csr_addr_t ADDR_TIMEH     = 12'hC81;

    // Machine trap setup
    localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
    localparam csr_addr_t ADDR_MISA      = 12'h301;
    localparam csr_addr_t ADDR_MIE       = 12'h304;
    localparam csr_addr_t ADDR_MTVEC     = 12'h305;

    // Machine trap handling
    localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;
    localparam csr_addr_t ADDR_MEPC      = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
    localparam csr_addr_t ADDR_MIP       = 12'h344;

    // Custom machine read/write range, timer compare halves
    localparam csr_addr_t ADDR_MTIMECMP  = 12'h7C0;
    localparam csr_addr_t ADDR_MTIMECMPH = 12'h7C1;

    // mcause values, bit 31 flags an interrupt
    localparam xlen_t CAUSE_ECALL_U      = 32'd8;
    localparam xlen_t CAUSE_ECALL_M      = 32'd11;
    localparam xlen_t CAUSE_M_TIMER_IRQ  = 32'h8000_0007;

    // MXL = 1 for RV32, extension bits A, I and M
    localparam xlen_t MISA_VALUE         = 32'h4000_1101;

    // mstatus fields
    localparam int MSTATUS_MIE           = 3;
    localparam int MSTATUS_MPIE          = 7;
    localparam int MSTATUS_MPP_LO        = 11;

    // Machine timer bit in mie and mip
    localparam int MIX_MT                = 7;

endpackage
